/* bridge_pkg.sv */
// Host bridge shared definitions
`default_nettype none

package bridge_pkg;

	localparam int BYTE_W = 8; // one host byte

	// opcode byte from the host
	typedef enum logic [7:0] {
		CMD_WRITE = 8'hEA, // 4 address bytes then 4 data bytes
		CMD_READ  = 8'h22  // 4 address bytes
	} cmd_op_e;

	// kind of request the parser has accepted
	typedef enum logic [1:0] {
		REQ_WRITE,
		REQ_READ,
		REQ_INVALID
	} req_kind_e;

	// status byte sent back to the host
	typedef enum logic [7:0] {
		RESP_OK      = 8'hAC,
		RESP_TIMEOUT = 8'hEE,
		RESP_INVALID = 8'hE1
	} resp_code_e;

endpackage

`default_nettype wire

/* host_cmd_parser.sv */
// Host command parser
`timescale 1ns/1ps
`default_nettype none

module host_cmd_parser #(
	parameter int RX_CREDITS = 2
) (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          rx_valid_i,
	input  logic [bridge_pkg::BYTE_W-1:0] rx_byte_i,
	input  logic                          resp_sent_i,
	output logic                          rx_credit_o,
	output logic [31:0]                   bus_addr_o,
	output logic [31:0]                   bus_wdata_o,
	output logic                          bus_write_o,
	output logic                          bus_read_o,
	output logic                          req_start_o,
	output bridge_pkg::req_kind_e         req_kind_o
);

	localparam int PTR_W = (RX_CREDITS > 1) ? $clog2(RX_CREDITS) : 1;
	localparam int CNT_W = $clog2(RX_CREDITS + 1);

	typedef enum logic [1:0] {
		IDLE,      // waiting for an opcode byte
		COLLECT,   // shifting in operand bytes
		ISSUE,     // transfer pulse cycle
		WAIT_RESP  // response still going out
	} state_e;

	state_e state;
	state_e state_nxt;
	bridge_pkg::req_kind_e kind_q;
	bridge_pkg::req_kind_e kind_nxt;

	logic [bridge_pkg::BYTE_W-1:0] buf_mem [RX_CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] buf_cnt;
	logic [bridge_pkg::BYTE_W-1:0] head_byte;
	logic pop;

	logic [63:0] asm_q; // operand bytes, msb first
	logic [2:0] opnd_cnt;
	logic [2:0] opnd_last;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		logic [PTR_W-1:0] r;
		if (p == PTR_W'(RX_CREDITS - 1))
			r = '0;
		else
			r = p + 1'b1;
		return r;
	endfunction

	// rx byte buffer, sized by the credits the host holds
	assign head_byte = buf_mem[rd_ptr];
	assign pop = ((state == IDLE) || (state == COLLECT)) && (buf_cnt != '0);
	assign rx_credit_o = pop; // credit goes back as the byte leaves

	always_ff @(posedge clk) begin
		if (rx_valid_i)
			buf_mem[wr_ptr] <= rx_byte_i;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			buf_cnt <= '0;
		end else begin
			if (rx_valid_i)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({rx_valid_i, pop})
				2'b10:   buf_cnt <= buf_cnt + 1'b1;
				2'b01:   buf_cnt <= buf_cnt - 1'b1;
				default: buf_cnt <= buf_cnt;
			endcase
		end
	end

	// command decode and sequencing
	assign opnd_last = (kind_q == bridge_pkg::REQ_WRITE) ? 3'd7 : 3'd3;

	always_comb begin
		state_nxt = state;
		kind_nxt = kind_q;
		case (state)
			IDLE: begin
				if (pop) begin
					case (bridge_pkg::cmd_op_e'(head_byte))
						bridge_pkg::CMD_WRITE: begin
							kind_nxt = bridge_pkg::REQ_WRITE;
							state_nxt = COLLECT;
						end
						bridge_pkg::CMD_READ: begin
							kind_nxt = bridge_pkg::REQ_READ;
							state_nxt = COLLECT;
						end
						default: begin
							kind_nxt = bridge_pkg::REQ_INVALID; // no operands follow
							state_nxt = ISSUE;
						end
					endcase
				end
			end
			COLLECT: begin
				if (pop && (opnd_cnt == opnd_last))
					state_nxt = ISSUE;
			end
			ISSUE: state_nxt = WAIT_RESP;
			WAIT_RESP: begin
				if (resp_sent_i)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
			kind_q <= bridge_pkg::REQ_INVALID;
			opnd_cnt <= '0;
		end else begin
			state <= state_nxt;
			kind_q <= kind_nxt;
			if (state == IDLE)
				opnd_cnt <= '0;
			else if ((state == COLLECT) && pop)
				opnd_cnt <= opnd_cnt + 1'b1;
		end
	end

	// shift operand bytes in, first byte ends up on top
	always_ff @(posedge clk) begin
		if ((state == COLLECT) && pop)
			asm_q <= {asm_q[63-bridge_pkg::BYTE_W:0], head_byte};
	end

	assign bus_addr_o = (kind_q == bridge_pkg::REQ_WRITE) ? asm_q[63:32] : asm_q[31:0];
	assign bus_wdata_o = (kind_q == bridge_pkg::REQ_WRITE) ? asm_q[31:0] : 32'h0;

	assign req_start_o = (state == ISSUE);
	assign bus_write_o = (state == ISSUE) && (kind_q == bridge_pkg::REQ_WRITE);
	assign bus_read_o = (state == ISSUE) && (kind_q == bridge_pkg::REQ_READ);
	assign req_kind_o = kind_q;

endmodule

`default_nettype wire

/* bus_response_watchdog.sv */
// Bus response watchdog
`timescale 1ns/1ps
`default_nettype none

module bus_response_watchdog #(
	parameter int TIMEOUT_CYCLES = 32
) (
	input  logic        clk,
	input  logic        rstn,
	input  logic        bus_write_i,
	input  logic        bus_read_i,
	input  logic        bus_resp_valid_i,
	input  logic [31:0] bus_rdata_i,
	output logic        xfer_done_o,
	output logic        xfer_timeout_o,
	output logic [31:0] xfer_rdata_o
);

	localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

	logic busy;
	logic [CNT_W-1:0] cnt;
	logic resp_hit;
	logic expired;

	assign resp_hit = busy && bus_resp_valid_i; // late responses fall outside busy
	assign expired = busy && (cnt == CNT_W'(1)) && !bus_resp_valid_i;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			busy <= 1'b0;
			cnt <= '0;
			xfer_done_o <= 1'b0;
			xfer_timeout_o <= 1'b0;
		end else begin
			xfer_done_o <= resp_hit || expired;
			if (bus_write_i || bus_read_i) begin
				busy <= 1'b1;
				cnt <= CNT_W'(TIMEOUT_CYCLES - 1); // done lands TIMEOUT_CYCLES later
			end else if (resp_hit) begin
				busy <= 1'b0;
				xfer_timeout_o <= 1'b0;
			end else if (expired) begin
				busy <= 1'b0;
				xfer_timeout_o <= 1'b1;
			end else if (busy) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resp_hit)
			xfer_rdata_o <= bus_rdata_i;
	end

endmodule

`default_nettype wire

/* response_formatter.sv */
// Host response formatter
`timescale 1ns/1ps
`default_nettype none

module response_formatter #(
	parameter int TX_CREDITS = 4
) (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          req_start_i,
	input  bridge_pkg::req_kind_e         req_kind_i,
	input  logic                          xfer_done_i,
	input  logic                          xfer_timeout_i,
	input  logic [31:0]                   xfer_rdata_i,
	input  logic                          tx_credit_i,
	output logic                          tx_valid_o,
	output logic [bridge_pkg::BYTE_W-1:0] tx_byte_o,
	output logic                          resp_sent_o
);

	localparam int CRED_W = $clog2(TX_CREDITS + 1);
	localparam int SREG_W = 5 * bridge_pkg::BYTE_W; // status plus 4 data bytes

	bridge_pkg::req_kind_e kind_q;
	logic [CRED_W-1:0] credits;
	logic [2:0] remain;
	logic [SREG_W-1:0] sreg;
	logic send;
	logic load_invalid;

	assign load_invalid = req_start_i && (req_kind_i == bridge_pkg::REQ_INVALID);
	assign send = (remain != 3'd0) && (credits != '0);
	assign tx_valid_o = send;
	assign tx_byte_o = sreg[SREG_W-1 -: bridge_pkg::BYTE_W];

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			kind_q <= bridge_pkg::REQ_INVALID;
		else if (req_start_i)
			kind_q <= req_kind_i;
	end

	// tx credit counter, a send and a return cancel out
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			credits <= CRED_W'(TX_CREDITS);
		end else begin
			case ({send, tx_credit_i})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// remaining byte count and end-of-response pulse
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			remain <= 3'd0;
			resp_sent_o <= 1'b0;
		end else begin
			resp_sent_o <= send && (remain == 3'd1);
			if (load_invalid)
				remain <= 3'd1;
			else if (xfer_done_i) begin
				if (!xfer_timeout_i && (kind_q == bridge_pkg::REQ_READ))
					remain <= 3'd5; // status then read data
				else
					remain <= 3'd1;
			end else if (send)
				remain <= remain - 1'b1;
		end
	end

	// byte shift register, top byte is on the wire
	always_ff @(posedge clk) begin
		if (load_invalid) begin
			sreg <= {bridge_pkg::RESP_INVALID, 32'h0};
		end else if (xfer_done_i) begin
			if (xfer_timeout_i)
				sreg <= {bridge_pkg::RESP_TIMEOUT, 32'h0};
			else
				sreg <= {bridge_pkg::RESP_OK, xfer_rdata_i}; // data unused for writes
		end else if (send) begin
			sreg <= {sreg[SREG_W-bridge_pkg::BYTE_W-1:0], {bridge_pkg::BYTE_W{1'b0}}};
		end
	end

endmodule

`default_nettype wire

/* host_bridge_top.sv */
// UART host to register bus bridge
`timescale 1ns/1ps
`default_nettype none

module host_bridge_top #(
	parameter int RX_CREDITS     = 2,
	parameter int TX_CREDITS     = 4,
	parameter int TIMEOUT_CYCLES = 32
) (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          rx_valid_i,
	input  logic [bridge_pkg::BYTE_W-1:0] rx_byte_i,
	output logic                          rx_credit_o,
	output logic                          tx_valid_o,
	output logic [bridge_pkg::BYTE_W-1:0] tx_byte_o,
	input  logic                          tx_credit_i,
	output logic [31:0]                   bus_addr_o,
	output logic [31:0]                   bus_wdata_o,
	output logic                          bus_write_o,
	output logic                          bus_read_o,
	input  logic                          bus_resp_valid_i,
	input  logic [31:0]                   bus_rdata_i
);

	logic req_start;
	bridge_pkg::req_kind_e req_kind;
	logic xfer_done;
	logic xfer_timeout;
	logic [31:0] xfer_rdata;
	logic resp_sent;

	host_cmd_parser #(
		.RX_CREDITS (RX_CREDITS)
	) host_cmd_parser_inst (
		.clk         (clk),
		.rstn        (rstn),
		.rx_valid_i  (rx_valid_i),
		.rx_byte_i   (rx_byte_i),
		.resp_sent_i (resp_sent),
		.rx_credit_o (rx_credit_o),
		.bus_addr_o  (bus_addr_o),
		.bus_wdata_o (bus_wdata_o),
		.bus_write_o (bus_write_o),
		.bus_read_o  (bus_read_o),
		.req_start_o (req_start),
		.req_kind_o  (req_kind)
	);

	bus_response_watchdog #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) bus_response_watchdog_inst (
		.clk              (clk),
		.rstn             (rstn),
		.bus_write_i      (bus_write_o),
		.bus_read_i       (bus_read_o),
		.bus_resp_valid_i (bus_resp_valid_i),
		.bus_rdata_i      (bus_rdata_i),
		.xfer_done_o      (xfer_done),
		.xfer_timeout_o   (xfer_timeout),
		.xfer_rdata_o     (xfer_rdata)
	);

	response_formatter #(
		.TX_CREDITS (TX_CREDITS)
	) response_formatter_inst (
		.clk            (clk),
		.rstn           (rstn),
		.req_start_i    (req_start),
		.req_kind_i     (req_kind),
		.xfer_done_i    (xfer_done),
		.xfer_timeout_i (xfer_timeout),
		.xfer_rdata_i   (xfer_rdata),
		.tx_credit_i    (tx_credit_i),
		.tx_valid_o     (tx_valid_o),
		.tx_byte_o      (tx_byte_o),
		.resp_sent_o    (resp_sent)
	);

endmodule

`default_nettype wire

/* host_bridge_checker.sv */
// Host bridge response checker
`timescale 1ns/1ps
`default_nettype none

module host_bridge_checker #(
	parameter int TX_CREDITS = 4
) (
	input  logic        clk,
	input  logic        rstn,
	input  logic        rx_valid_i,
	input  logic [7:0]  rx_byte_i,
	input  logic        rx_credit_i,
	input  logic        tx_valid_i,
	input  logic [7:0]  tx_byte_i,
	input  logic        tx_credit_i,
	input  logic [31:0] bus_addr_i,
	input  logic [31:0] bus_wdata_i,
	input  logic        bus_write_i,
	input  logic        bus_read_i,
	output logic [31:0] errors_o,
	output logic [31:0] checks_o,
	output logic [31:0] pending_o
);

	logic [31:0] shadow [16] = '{default: 32'h0};
	logic [7:0] frame [9] = '{default: 8'h0};
	logic [7:0] exp_q [$]; // response bytes still owed to the host
	logic [64:0] xfer_q [$]; // write flag, address, data of each owed transfer
	logic [3:0] frame_len = 4'd0;
	logic [3:0] need = 4'd1;
	int rx_sent = 0;
	int rx_ret = 0;
	int tx_out = 0; // tx credits held by the host
	int err_cnt = 0;
	int chk_cnt = 0;

	// expected reply, first byte in the top bits of resp
	function automatic int ref_response(input logic [7:0] op, input logic [31:0] addr,
		output logic [39:0] resp);
		int len;
		len = 1;
		resp = '0;
		case (bridge_pkg::cmd_op_e'(op))
			bridge_pkg::CMD_WRITE:
				resp[39:32] = (addr < 32'h40) ? bridge_pkg::RESP_OK : bridge_pkg::RESP_TIMEOUT;
			bridge_pkg::CMD_READ: begin
				if (addr < 32'h40) begin
					resp = {bridge_pkg::RESP_OK, shadow[addr[5:2]]}; // word from bits 5:2
					len = 5;
				end else
					resp[39:32] = bridge_pkg::RESP_TIMEOUT;
			end
			default: resp[39:32] = bridge_pkg::RESP_INVALID;
		endcase
		return len;
	endfunction

	task automatic report_failure(input string msg);
		$display("Checker: %s at %0t", msg, $time);
		err_cnt++;
	endtask

	always @(posedge clk) begin : monitor
		logic [39:0] resp;
		logic [31:0] addr;
		int len;
		if (rstn) begin
			if ((rx_sent == 0) && (rx_credit_i || tx_valid_i || bus_write_i || bus_read_i))
				report_failure("output active after reset before any rx byte");
			if (tx_valid_i && (tx_out >= TX_CREDITS))
				report_failure("tx_valid_o asserted with every tx credit outstanding");
			if (tx_valid_i && (exp_q.size() == 0))
				report_failure("tx byte sent with no response expected");
			else if (tx_valid_i) begin
				chk_cnt++;
				if (tx_byte_i !== exp_q[0]) begin
					$display("** Error: tx_byte_o expected %h, got %h", exp_q[0], tx_byte_i);
					err_cnt++;
				end
				void'(exp_q.pop_front());
			end
			if ((bus_write_i || bus_read_i) && (xfer_q.size() == 0))
				report_failure("bus transfer with no valid command pending");
			else if (bus_write_i || bus_read_i) begin
				chk_cnt++;
				if ({bus_write_i, bus_read_i} !== {xfer_q[0][64], !xfer_q[0][64]})
					report_failure("bus transfer pulse of the wrong kind");
				if (bus_addr_i !== xfer_q[0][63:32]) begin
					$display("** Error: bus_addr_o expected %h, got %h",
						xfer_q[0][63:32], bus_addr_i);
					err_cnt++;
				end
				if (bus_write_i && (bus_wdata_i !== xfer_q[0][31:0])) begin
					$display("** Error: bus_wdata_o expected %h, got %h",
						xfer_q[0][31:0], bus_wdata_i);
					err_cnt++;
				end
				void'(xfer_q.pop_front());
			end
			tx_out = tx_out + int'(tx_valid_i) - int'(tx_credit_i);
			rx_sent = rx_sent + int'(rx_valid_i);
			rx_ret = rx_ret + int'(rx_credit_i);
			if (rx_ret > rx_sent)
				report_failure("rx credits returned exceed bytes sent");
			if (rx_valid_i) begin
				frame[frame_len] = rx_byte_i;
				frame_len++;
				need = (frame[0] == bridge_pkg::CMD_WRITE) ? 4'd9 :
					((frame[0] == bridge_pkg::CMD_READ) ? 4'd5 : 4'd1);
				if (frame_len == need) begin
					addr = {frame[1], frame[2], frame[3], frame[4]}; // msb first
					len = ref_response(frame[0], addr, resp);
					for (int i = 0; i < len; i++) begin
						exp_q.push_back(resp[39:32]);
						resp = resp << 8;
					end
					if (need > 4'd1)
						xfer_q.push_back({(need == 4'd9), addr,
							frame[5], frame[6], frame[7], frame[8]});
					if ((need == 4'd9) && (addr < 32'h40))
						shadow[addr[5:2]] = {frame[5], frame[6], frame[7], frame[8]};
					frame_len = 4'd0;
				end
			end
		end
		errors_o <= err_cnt;
		checks_o <= chk_cnt;
		pending_o <= exp_q.size() + xfer_q.size() + 32'(frame_len);
	end

endmodule

`default_nettype wire

/* tb_host_bridge.sv */
// Host bridge testbench
`timescale 1ns/1ps
`default_nettype none

module tb_host_bridge;

	localparam int RX_CREDITS = 2;
	localparam int TX_CREDITS = 4;
	localparam int TIMEOUT_CYCLES = 32;
	localparam int N_RANDOM = 24;
	localparam int N_CMDS = 8 + N_RANDOM; // scripted plus random
	localparam int MAX_GAP = 3;
	localparam int MAX_CRED_DELAY = 4;
	localparam int LONG_PAUSE = 60; // tx sink stall
	localparam int CYCLE_LIMIT = 2 * N_CMDS *
		(9 * MAX_GAP + TIMEOUT_CYCLES + 5 * MAX_CRED_DELAY + LONG_PAUSE);

	logic clk = 1'b0;
	logic rstn;
	logic rx_valid;
	logic [7:0] rx_byte;
	logic rx_credit;
	logic tx_valid;
	logic [7:0] tx_byte;
	logic tx_credit;
	logic [31:0] bus_addr;
	logic [31:0] bus_wdata;
	logic bus_write;
	logic bus_read;
	logic bus_resp_valid;
	logic [31:0] bus_rdata;
	logic [31:0] errors;
	logic [31:0] checks;
	logic [31:0] pending;
	logic [31:0] bus_mem [16] = '{default: 32'h0};
	int seed = 32'hd7bcdcc2;
	int host_cred;
	int tx_seen = 0;
	int tx_returned = 0;
	int cycles = 0;

	host_bridge_top #(
		.RX_CREDITS     (RX_CREDITS),
		.TX_CREDITS     (TX_CREDITS),
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) host_bridge_top_inst (
		.clk              (clk),
		.rstn             (rstn),
		.rx_valid_i       (rx_valid),
		.rx_byte_i        (rx_byte),
		.rx_credit_o      (rx_credit),
		.tx_valid_o       (tx_valid),
		.tx_byte_o        (tx_byte),
		.tx_credit_i      (tx_credit),
		.bus_addr_o       (bus_addr),
		.bus_wdata_o      (bus_wdata),
		.bus_write_o      (bus_write),
		.bus_read_o       (bus_read),
		.bus_resp_valid_i (bus_resp_valid),
		.bus_rdata_i      (bus_rdata)
	);

	host_bridge_checker #(
		.TX_CREDITS (TX_CREDITS)
	) host_bridge_checker_inst (
		.clk         (clk),
		.rstn        (rstn),
		.rx_valid_i  (rx_valid),
		.rx_byte_i   (rx_byte),
		.rx_credit_i (rx_credit),
		.tx_valid_i  (tx_valid),
		.tx_byte_i   (tx_byte),
		.tx_credit_i (tx_credit),
		.bus_addr_i  (bus_addr),
		.bus_wdata_i (bus_wdata),
		.bus_write_i (bus_write),
		.bus_read_i  (bus_read),
		.errors_o    (errors),
		.checks_o    (checks),
		.pending_o   (pending)
	);

	always #5 clk = ~clk;

	always @(posedge clk or negedge rstn) begin
		if (!rstn)
			host_cred <= RX_CREDITS;
		else
			host_cred <= host_cred - int'(rx_valid) + int'(rx_credit); // host's own view
	end

	always @(posedge clk) begin
		if (tx_valid)
			tx_seen <= tx_seen + 1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout: run stopped after %0d cycles with %0d bytes owed", cycles, pending);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		while (host_cred == 0)
			wait_cycles(1); // no credit, hold off
		rx_valid = 1'b1;
		rx_byte = b;
		wait_cycles(1);
		rx_valid = 1'b0;
	endtask

	task automatic send_frame(input logic [7:0] op, input logic [31:0] addr,
		input logic [31:0] data);
		logic [63:0] opnd;
		int n;
		opnd = {addr, data};
		n = (op == bridge_pkg::CMD_WRITE) ? 8 : ((op == bridge_pkg::CMD_READ) ? 4 : 0);
		wait_cycles({$random(seed)} % (MAX_GAP + 1));
		send_byte(op);
		for (int i = 0; i < n; i++) begin
			wait_cycles({$random(seed)} % (MAX_GAP + 1));
			send_byte(opnd[63:56]);
			opnd = opnd << 8;
		end
	endtask

	// register bus slave, silent above 32'h40
	initial begin : bus_model
		logic [31:0] addr;
		int lat;
		bus_resp_valid = 1'b0;
		bus_rdata = 32'h0;
		forever begin
			@(posedge clk);
			if (rstn && (bus_write || bus_read) && (bus_addr < 32'h40)) begin
				addr = bus_addr;
				if (bus_write)
					bus_mem[addr[5:2]] = bus_wdata;
				lat = 1 + {$random(seed)} % 5;
				repeat (lat - 1) @(posedge clk);
				#1;
				bus_resp_valid = 1'b1;
				bus_rdata = bus_mem[addr[5:2]];
				@(posedge clk);
				#1;
				bus_resp_valid = 1'b0;
			end
		end
	end

	// tx sink, returns each credit late and stalls now and then
	initial begin : tx_sink
		int d;
		tx_credit = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			tx_credit = 1'b0;
			if (tx_seen > tx_returned) begin
				d = {$random(seed)} % (MAX_CRED_DELAY + 1);
				if ({$random(seed)} % 8 == 0)
					d = LONG_PAUSE;
				wait_cycles(d);
				tx_credit = 1'b1;
				tx_returned++;
			end
		end
	end

	initial begin : stimulus
		logic [7:0] op;
		logic [31:0] addr;
		int sel;
		rstn = 1'b0;
		rx_valid = 1'b0;
		rx_byte = 8'h0;
		wait_cycles(8);
		rstn = 1'b1;
		wait_cycles(10); // quiet outputs expected here
		send_frame(bridge_pkg::CMD_WRITE, 32'h10, 32'hDEADBEEF);
		send_frame(bridge_pkg::CMD_READ, 32'h10, 32'h0);
		send_frame(bridge_pkg::CMD_READ, 32'h24, 32'h0); // never written
		send_frame(bridge_pkg::CMD_WRITE, 32'h40, 32'h12345678);
		send_frame(bridge_pkg::CMD_READ, 32'h1000, 32'h0);
		send_frame(bridge_pkg::CMD_READ, 32'h10, 32'h0);
		send_frame(8'h5A, 32'h0, 32'h0);
		send_frame(bridge_pkg::CMD_WRITE, 32'h3C, 32'hA5C30F96);
		for (int k = 0; k < N_RANDOM; k++) begin
			sel = {$random(seed)} % 10;
			if (sel < 5)
				op = bridge_pkg::CMD_WRITE;
			else if (sel < 9)
				op = bridge_pkg::CMD_READ;
			else
				op = 8'($random(seed));
			if ({$random(seed)} % 8 == 0)
				addr = 32'h40 + ({$random(seed)} % 32'h100);
			else
				addr = {$random(seed)} & 32'h3F;
			send_frame(op, addr, $random(seed));
		end
		while (pending != 0)
			wait_cycles(1);
		wait_cycles(20); // catch stray bytes
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* host_bridge.f */
bridge_pkg.sv
host_cmd_parser.sv
bus_response_watchdog.sv
response_formatter.sv
host_bridge_top.sv
host_bridge_checker.sv
tb_host_bridge.sv

/* run_sim.sh */
#!/bin/sh
# build and run the host bridge simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_host_bridge -f host_bridge.f -o sim_host_bridge
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_host_bridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation passed" sim.log; then
	exit 0
fi
exit 1
